// ==== rtl/task_pkg.sv ====
package task_pkg;

	localparam int num_cores = 4;        // Fixed by the packed mask fields

	typedef logic [31:0] word_t;
	typedef logic [5:0] addr_t;          // Task memory address as carried on the buses

	typedef enum logic [1:0] {
		fence_none = 2'd0,               // Wait for own cores only
		fence_acq  = 2'd1,               // Next task waits for all cores
		fence_rel  = 2'd2                // This task waits for all cores
	} fence_e;

	localparam int spare_w = 32 - 22 - num_cores;

	// Control frame, first word of every task
	typedef struct packed {
		logic                 is_ctrl;
		fence_e               fence;
		logic                 stop;
		addr_t                stop_addr;
		logic [num_cores-1:0] core_mask;
		logic [3:0]           insn_count;
		logic [7:0]           r0_init;
		logic [spare_w-1:0]   spare;     // Written as zero
	} ctrl_frame_t;

	// Host write request
	typedef struct packed {
		addr_t addr;
		word_t data;
	} mem_wr_t;

	// Scheduler read request
	typedef struct packed {
		addr_t addr;
	} mem_rd_t;

endpackage

// ==== rtl/core_pkg.sv ====
package core_pkg;

	typedef enum logic [2:0] {
		op_add = 3'd0,                   // r0 + operand
		op_sub = 3'd1,                   // r0 - operand
		op_xor = 3'd2,                   // r0 ^ operand
		op_shl = 3'd3,                   // r0 << 1
		op_nop = 3'd4
	} opcode_e;

	// Instruction frame payload, low bits of the memory word
	typedef struct packed {
		opcode_e    opcode;
		logic [7:0] operand;
	} insn_t;

	localparam int insn_w = $bits(insn_t);

endpackage

// ==== rtl/task_mem.sv ====
`timescale 1ns/100ps

module task_mem #(
	parameter int ADDR_W = 6
) (
	input  logic              clk,
	input  logic              en,
	input  logic              we,
	input  logic [ADDR_W-1:0] addr,
	input  task_pkg::word_t   wdata,
	output task_pkg::word_t   rdata
);

	task_pkg::word_t mem [2**ADDR_W];

	always_ff @(posedge clk) begin
		if (en) begin
			if (we) begin
				mem[addr] <= wdata;
			end else begin
				rdata <= mem[addr];      // One cycle read latency
			end
		end
	end

endmodule

// ==== rtl/mem_arbiter.sv ====
`timescale 1ns/100ps

module mem_arbiter #(
	parameter int ADDR_W = 6
) (
	input  logic              clk,
	input  logic              reset,
	input  logic              host_wr_valid,
	input  task_pkg::mem_wr_t host_wr,
	output logic              host_wr_ready,
	input  logic              rd_valid,
	input  task_pkg::mem_rd_t rd_req,
	output logic              rd_ready,
	output logic              rd_data_valid,
	output task_pkg::word_t   rd_data
);

	logic              wr_fire;
	logic              rd_fire;
	logic              mem_en;
	logic [ADDR_W-1:0] mem_addr;
	logic              rd_pend;

	// Host owns the port whenever it asks
	assign rd_ready = !host_wr_valid;
	assign wr_fire  = host_wr_valid && host_wr_ready;
	assign rd_fire  = rd_valid && rd_ready;
	assign mem_en   = wr_fire || rd_fire;
	assign mem_addr = wr_fire ? ADDR_W'(host_wr.addr) : ADDR_W'(rd_req.addr);

	always_ff @(posedge clk) begin
		if (reset) begin
			host_wr_ready <= 1'b0;       // Port opens one cycle after reset
			rd_pend       <= 1'b0;
		end else begin
			host_wr_ready <= 1'b1;
			rd_pend       <= rd_fire;    // Matches memory latency
		end
	end

	assign rd_data_valid = rd_pend;

	task_mem #(
		.ADDR_W(ADDR_W)
	) u_task_mem (
		.clk  (clk),
		.en   (mem_en),
		.we   (wr_fire),
		.addr (mem_addr),
		.wdata(host_wr.data),
		.rdata(rd_data)
	);

endmodule

// ==== rtl/task_scheduler.sv ====
`timescale 1ns/100ps

module task_scheduler #(
	parameter int ADDR_W = 6
) (
	input  logic                           clk,
	input  logic                           reset,
	input  logic                           go,
	input  logic                           resume,
	input  logic [task_pkg::num_cores-1:0] core_busy,
	output logic                           rd_valid,
	output task_pkg::mem_rd_t              rd_req,
	input  logic                           rd_ready,
	input  logic                           rd_data_valid,
	input  task_pkg::word_t                rd_data,
	output logic                           insn_valid,
	output core_pkg::insn_t                insn,
	output logic [task_pkg::num_cores-1:0] load_mask,
	output logic                           r0_load,
	output logic [7:0]                     r0_value,
	output logic [task_pkg::num_cores-1:0] start,
	output logic                           halted
);

	typedef enum logic [2:0] {
		st_idle,
		st_fetch_ctrl,
		st_wait_ctrl,
		st_fence,
		st_load,
		st_start,
		st_drain,
		st_halt
	} state_e;

	state_e                state;
	logic [ADDR_W-1:0]     task_ptr;
	task_pkg::ctrl_frame_t ctrl;
	task_pkg::ctrl_frame_t rd_frame;
	logic [3:0]            issue_left;     // Instruction reads not yet issued
	logic                  rd_out;         // One read in flight
	logic                  acq_pend;
	logic                  all_idle;
	logic                  mask_idle;
	logic                  fence_ok;
	logic                  rd_fire;

	assign rd_frame  = task_pkg::ctrl_frame_t'(rd_data);
	assign all_idle  = core_busy == '0;
	assign mask_idle = (core_busy & ctrl.core_mask) == '0;

	// Release or a preceding acquire needs the whole array quiet
	assign fence_ok = (ctrl.fence == task_pkg::fence_rel || acq_pend) ? all_idle : mask_idle;

	assign rd_valid    = state == st_fetch_ctrl ||
		(state == st_load && issue_left != '0 && !rd_out);
	assign rd_fire     = rd_valid && rd_ready;
	assign rd_req.addr = task_pkg::addr_t'(task_ptr);

	assign insn_valid = state == st_load && rd_data_valid;
	assign insn       = core_pkg::insn_t'(rd_data[core_pkg::insn_w-1:0]);
	assign load_mask  = (state == st_fence || state == st_load) ? ctrl.core_mask : '0;
	assign r0_load    = state == st_fence && fence_ok;
	assign r0_value   = ctrl.r0_init;
	assign start      = (state == st_start) ? ctrl.core_mask : '0;
	assign halted     = state == st_halt;

	always_ff @(posedge clk) begin
		if (state == st_wait_ctrl && rd_data_valid && rd_frame.is_ctrl) begin
			ctrl <= rd_frame;
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			state      <= st_idle;
			task_ptr   <= '0;
			issue_left <= '0;
			rd_out     <= 1'b0;
			acq_pend   <= 1'b0;
		end else begin
			case (state)
				st_idle: begin
					if (go) begin
						state <= st_fetch_ctrl;
					end
				end
				st_fetch_ctrl: begin
					if (rd_fire) begin
						state <= st_wait_ctrl;
					end
				end
				st_wait_ctrl: begin
					if (rd_data_valid) begin
						if (rd_frame.is_ctrl) begin
							task_ptr <= task_ptr + 1'b1;
							state    <= st_fence;
						end else begin
							state <= st_fetch_ctrl;    // Poll same word again
						end
					end
				end
				st_fence: begin
					if (fence_ok) begin
						issue_left <= ctrl.insn_count;
						state      <= (ctrl.insn_count == '0) ? st_start : st_load;
					end
				end
				st_load: begin
					if (rd_fire) begin
						rd_out     <= 1'b1;
						task_ptr   <= task_ptr + 1'b1;
						issue_left <= issue_left - 1'b1;
					end
					if (rd_data_valid) begin
						rd_out <= 1'b0;
						if (issue_left == '0) begin
							state <= st_start;
						end
					end
				end
				st_start: begin
					acq_pend <= ctrl.fence == task_pkg::fence_acq;
					state    <= ctrl.stop ? st_drain : st_fetch_ctrl;
				end
				st_drain: begin
					if (all_idle) begin
						state <= st_halt;
					end
				end
				st_halt: begin
					if (resume) begin
						task_ptr <= ADDR_W'(ctrl.stop_addr);
						acq_pend <= 1'b1;              // Resumed task sees a quiet array
						state    <= st_fetch_ctrl;
					end
				end
				default: begin
					state <= st_idle;
				end
			endcase
		end
	end

endmodule

// ==== rtl/mini_core.sv ====
`timescale 1ns/100ps

module mini_core #(
	parameter int PROG_DEPTH = 8
) (
	input  logic            clk,
	input  logic            reset,
	input  logic            select,
	input  logic            insn_valid,
	input  core_pkg::insn_t insn,
	input  logic            r0_load,
	input  logic [7:0]      r0_value,
	input  logic            start_bit,
	output logic            busy,
	output logic [7:0]      r0
);

	localparam int idx_w = $clog2(PROG_DEPTH);
	localparam int cnt_w = idx_w + 1;

	core_pkg::insn_t  prog [PROG_DEPTH];
	logic [cnt_w-1:0] count;               // Buffered instructions
	logic [cnt_w-1:0] pc;
	logic             buf_wr;
	core_pkg::insn_t  cur;
	logic [7:0]       r0_next;

	assign buf_wr = select && insn_valid && !busy && count < cnt_w'(PROG_DEPTH);
	assign cur    = prog[pc[idx_w-1:0]];

	always_comb begin
		case (cur.opcode)
			core_pkg::op_add: r0_next = r0 + cur.operand;
			core_pkg::op_sub: r0_next = r0 - cur.operand;
			core_pkg::op_xor: r0_next = r0 ^ cur.operand;
			core_pkg::op_shl: r0_next = {r0[6:0], 1'b0};
			default:          r0_next = r0;
		endcase
	end

	always_ff @(posedge clk) begin
		if (buf_wr) begin
			prog[count[idx_w-1:0]] <= insn;
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			count <= '0;
			pc    <= '0;
			busy  <= 1'b0;
			r0    <= '0;
		end else if (busy) begin
			r0 <= r0_next;                  // One instruction per cycle
			pc <= pc + 1'b1;
			if (pc == count - 1'b1) begin
				busy <= 1'b0;
			end
		end else if (select && r0_load) begin
			r0    <= r0_value;
			count <= '0;                    // New task empties the buffer
		end else if (buf_wr) begin
			count <= count + 1'b1;
		end else if (start_bit) begin
			busy <= count != '0;
			pc   <= '0;
		end
	end

endmodule

// ==== rtl/sched_top.sv ====
`timescale 1ns/100ps

module sched_top #(
	parameter int ADDR_W     = 6,
	parameter int PROG_DEPTH = 8
) (
	input  logic                                clk,
	input  logic                                reset,
	input  logic                                host_wr_valid,
	input  task_pkg::mem_wr_t                   host_wr,
	output logic                                host_wr_ready,
	input  logic                                go,
	input  logic                                resume,
	output logic                                halted,
	output logic [task_pkg::num_cores-1:0]      task_start,
	output logic [task_pkg::num_cores-1:0]      core_busy,
	output logic [task_pkg::num_cores-1:0][7:0] core_r0
);

	logic                           rd_valid;
	task_pkg::mem_rd_t              rd_req;
	logic                           rd_ready;
	logic                           rd_data_valid;
	task_pkg::word_t                rd_data;
	logic                           insn_valid;
	core_pkg::insn_t                insn;
	logic [task_pkg::num_cores-1:0] load_mask;
	logic                           r0_load;
	logic [7:0]                     r0_value;

	mem_arbiter #(
		.ADDR_W(ADDR_W)
	) u_mem_arbiter (
		.clk          (clk),
		.reset        (reset),
		.host_wr_valid(host_wr_valid),
		.host_wr      (host_wr),
		.host_wr_ready(host_wr_ready),
		.rd_valid     (rd_valid),
		.rd_req       (rd_req),
		.rd_ready     (rd_ready),
		.rd_data_valid(rd_data_valid),
		.rd_data      (rd_data)
	);

	task_scheduler #(
		.ADDR_W(ADDR_W)
	) u_task_scheduler (
		.clk          (clk),
		.reset        (reset),
		.go           (go),
		.resume       (resume),
		.core_busy    (core_busy),
		.rd_valid     (rd_valid),
		.rd_req       (rd_req),
		.rd_ready     (rd_ready),
		.rd_data_valid(rd_data_valid),
		.rd_data      (rd_data),
		.insn_valid   (insn_valid),
		.insn         (insn),
		.load_mask    (load_mask),
		.r0_load      (r0_load),
		.r0_value     (r0_value),
		.start        (task_start),
		.halted       (halted)
	);

	for (genvar i = 0; i < task_pkg::num_cores; i++) begin : g_core
		mini_core #(
			.PROG_DEPTH(PROG_DEPTH)
		) u_mini_core (
			.clk       (clk),
			.reset     (reset),
			.select    (load_mask[i]),
			.insn_valid(insn_valid),
			.insn      (insn),
			.r0_load   (r0_load),
			.r0_value  (r0_value),
			.start_bit (task_start[i]),
			.busy      (core_busy[i]),
			.r0        (core_r0[i])
		);
	end

endmodule

// ==== bench/sched_checker.sv ====
`timescale 1ns/100ps

module sched_checker (
	input logic                           clk,
	input logic                           reset,
	input logic                           host_wr_valid,
	input task_pkg::mem_wr_t              host_wr,
	input logic                           host_wr_ready,
	input logic                           rd_valid,
	input task_pkg::mem_rd_t              rd_req,
	input logic                           rd_ready,
	input logic                           rd_data_valid,
	input logic                           insn_valid,
	input logic                           halted,
	input logic [task_pkg::num_cores-1:0] task_start,
	input logic [task_pkg::num_cores-1:0] core_busy
);

	a_reset_quiet: assert property (@(posedge clk)
		reset |=> !halted && task_start == '0 && core_busy == '0)
		else $error("halted, task_start or core_busy set after reset");

	// Host must hold a stalled write
	a_host_hold: assert property (@(posedge clk) disable iff (reset)
		host_wr_valid && !host_wr_ready |=> host_wr_valid && $stable(host_wr))
		else $error("host write changed while stalled");

	a_rd_hold: assert property (@(posedge clk) disable iff (reset)
		rd_valid && !rd_ready |=> rd_valid && $stable(rd_req))
		else $error("scheduler read request dropped or changed while stalled");

	a_rd_latency: assert property (@(posedge clk) disable iff (reset)
		rd_valid && rd_ready |=> rd_data_valid)
		else $error("read data missing one cycle after acceptance");

	a_rd_spurious: assert property (@(posedge clk) disable iff (reset)
		!(rd_valid && rd_ready) |=> !rd_data_valid)
		else $error("read data valid without an accepted read");

	// Fence rule seen from the cores
	a_start_idle: assert property (@(posedge clk) disable iff (reset)
		(task_start & core_busy) == '0)
		else $error("task_start hit a busy core");

	a_start_after_load: assert property (@(posedge clk) disable iff (reset)
		task_start != '0 |-> !insn_valid)
		else $error("task_start together with an instruction beat");

	a_busy_rise: assert property (@(posedge clk) disable iff (reset)
		task_start != '0 |=> (core_busy & $past(task_start)) == $past(task_start))
		else $error("started core did not go busy");

	a_halt_quiet: assert property (@(posedge clk) disable iff (reset)
		halted |-> task_start == '0 && core_busy == '0)
		else $error("activity while halted");

endmodule

// ==== bench/sched_tb.sv ====
`timescale 1ns/100ps

module sched_tb;

	localparam int n_tasks    = 6;
	localparam int first_b    = 4;           // Program B starts here in the table
	localparam int depth      = 8;
	localparam int max_cycles = 4000;        // Fill, two programs and their runs need under 700
	localparam logic [5:0] b_base = 6'd40;

	logic                                clk = 1'b0;
	logic                                reset;
	logic                                host_wr_valid;
	task_pkg::mem_wr_t                   host_wr;
	logic                                host_wr_ready;
	logic                                go;
	logic                                resume;
	logic                                halted;
	logic [task_pkg::num_cores-1:0]      task_start;
	logic [task_pkg::num_cores-1:0]      core_busy;
	logic [task_pkg::num_cores-1:0][7:0] core_r0;

	logic [31:0]                    lfsr;
	int                             cycles = 0;
	int                             starts_seen = 0;
	logic [task_pkg::num_cores-1:0] t_mask [n_tasks];
	task_pkg::fence_e               t_fence [n_tasks];
	logic [7:0]                     t_r0 [n_tasks];
	int                             t_count [n_tasks];
	core_pkg::opcode_e              t_op [n_tasks][depth];
	logic [7:0]                     t_arg [n_tasks][depth];
	logic [7:0]                     exp_r0 [task_pkg::num_cores];

	sched_top #(.ADDR_W(6), .PROG_DEPTH(depth)) u_sched_top (.*);

	bind sched_top sched_checker u_sched_checker (.*);

	always #5 clk = ~clk;

	function automatic logic [31:0] lfsr_step(input logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
	endfunction

	function automatic logic [7:0] rand_bits(input int n);
		logic [7:0] v;
		v = '0;
		for (int i = 0; i < n; i++) begin
			lfsr = lfsr_step(lfsr);
			v = {v[6:0], lfsr[0]};
		end
		return v;
	endfunction

	function automatic task_pkg::word_t ctrl_word(input task_pkg::fence_e fence, input logic stop,
			input logic [5:0] stop_addr, input logic [3:0] mask, input logic [3:0] count,
			input logic [7:0] r0);
		task_pkg::ctrl_frame_t f;
		f = '0;
		f.is_ctrl    = 1'b1;
		f.fence      = fence;
		f.stop       = stop;
		f.stop_addr  = stop_addr;
		f.core_mask  = mask;
		f.insn_count = count;
		f.r0_init    = r0;
		return task_pkg::word_t'(f);
	endfunction

	function automatic task_pkg::word_t insn_word(input core_pkg::opcode_e op, input logic [7:0] arg);
		return {21'd0, op, arg};
	endfunction

	// Bit 31 clear, so the scheduler keeps polling an unwritten slot
	function automatic task_pkg::word_t fill_word(input logic [5:0] addr);
		return {2'b01, addr, addr, addr, addr, addr};
	endfunction

	function automatic logic [7:0] run_program(input int k);
		logic [7:0] acc;
		acc = t_r0[k];
		for (int i = 0; i < t_count[k]; i++) begin
			case (t_op[k][i])
				core_pkg::op_add: acc = acc + t_arg[k][i];
				core_pkg::op_sub: acc = acc - t_arg[k][i];
				core_pkg::op_xor: acc = acc ^ t_arg[k][i];
				core_pkg::op_shl: acc = {acc[6:0], 1'b0};
				default:          acc = acc;
			endcase
		end
		return acc;
	endfunction

	task automatic abort_run();
		$display(">>> FAIL");
		$fatal(1);
	endtask

	task automatic mismatch(input string name, input logic [31:0] expected, input logic [31:0] actual);
		$display("** Error at %0t ns: %s expected 0x%0h, got 0x%0h", $time, name, expected, actual);
		abort_run();
	endtask

	task automatic give_up(input string what);
		$display("Error at %0t ns: %s", $time, what);
		abort_run();
	endtask

	task automatic build_task(input int k, input logic [3:0] mask, input task_pkg::fence_e fence,
			input int count);
		logic [7:0] pick;
		t_mask[k]  = mask;
		t_fence[k] = fence;
		t_r0[k]    = rand_bits(8);
		t_count[k] = (count > 0) ? count : int'(rand_bits(3)) + 1;   // Zero picks a random length
		for (int i = 0; i < t_count[k]; i++) begin
			pick = rand_bits(3);
			t_op[k][i]  = (pick > 8'd4) ? core_pkg::op_nop : core_pkg::opcode_e'(pick[2:0]);
			t_arg[k][i] = rand_bits(8);
		end
	endtask

	task automatic apply_task(input int k);
		for (int c = 0; c < task_pkg::num_cores; c++) begin
			if (t_mask[k][c]) begin
				exp_r0[c] = run_program(k);
			end
		end
	endtask

	// Entered right after a rising edge, returns on one
	task automatic write_word(input logic [5:0] addr, input task_pkg::word_t data);
		int gap;
		host_wr_valid <= 1'b1;
		host_wr.addr  <= addr;
		host_wr.data  <= data;
		@(negedge clk);
		while (!host_wr_ready) begin
			@(negedge clk);
		end
		@(posedge clk);                      // Accepted here
		gap = int'(rand_bits(2));
		if (gap != 0) begin
			host_wr_valid <= 1'b0;
			repeat (gap) @(posedge clk);
		end
	endtask

	task automatic release_bus();
		host_wr_valid <= 1'b0;
	endtask

	// Control frame goes last so a polled task is always complete
	task automatic store_task(input int k, input logic [5:0] base, output logic [5:0] next);
		for (int i = 0; i < t_count[k]; i++) begin
			write_word(base + 6'(i + 1), insn_word(t_op[k][i], t_arg[k][i]));
		end
		write_word(base, ctrl_word(t_fence[k], 1'b0, 6'd0, t_mask[k], 4'(t_count[k]), t_r0[k]));
		next = base + 6'(t_count[k] + 1);
	endtask

	task automatic wait_halted();
		@(negedge clk);
		while (!halted) begin
			@(negedge clk);
		end
	endtask

	task automatic check_r0();
		for (int c = 0; c < task_pkg::num_cores; c++) begin
			assert (core_r0[c] == exp_r0[c])
				else mismatch($sformatf("core_r0[%0d]", c), 32'(exp_r0[c]), 32'(core_r0[c]));
		end
	endtask

	always @(negedge clk) begin
		if (!reset && task_start != '0) begin
			assert (starts_seen < n_tasks) else give_up("task_start pulsed after the last task");
			assert (task_start == t_mask[starts_seen])
				else mismatch("task_start", 32'(t_mask[starts_seen]), 32'(task_start));
			if (t_fence[starts_seen] == task_pkg::fence_rel ||
					(starts_seen > 0 && t_fence[starts_seen - 1] == task_pkg::fence_acq)) begin
				assert (core_busy == '0) else mismatch("core_busy", 0, 32'(core_busy));
			end
			starts_seen <= starts_seen + 1;
		end
	end

	always @(posedge clk) begin
		cycles <= cycles + 1;
		if (cycles >= max_cycles) begin
			give_up("simulation ran into the cycle limit");
		end
	end

	initial begin
		logic [5:0] addr;
		lfsr          = 32'h2c61_d28b;
		reset         = 1'b1;
		host_wr_valid = 1'b0;
		host_wr       = '0;
		go            = 1'b0;
		resume        = 1'b0;
		for (int c = 0; c < task_pkg::num_cores; c++) begin
			exp_r0[c] = 8'h00;
		end
		build_task(0, 4'b0011, task_pkg::fence_none, 0);
		build_task(1, 4'b0100, task_pkg::fence_none, 0);
		build_task(2, 4'b0001, task_pkg::fence_none, 0);
		build_task(3, 4'b0010, task_pkg::fence_rel, 0);
		build_task(4, 4'b1100, task_pkg::fence_acq, depth);   // Still running when task 5 loads
		build_task(5, 4'b0001, task_pkg::fence_none, 1);
		repeat (5) @(posedge clk);
		reset <= 1'b0;
		for (int a = 0; a < 64; a++) begin
			write_word(6'(a), fill_word(6'(a)));   // First one meets the stalled port
		end
		release_bus();
		go <= 1'b1;
		@(posedge clk);
		go <= 1'b0;
		addr = 6'd0;
		for (int k = 0; k < first_b; k++) begin
			store_task(k, addr, addr);              // Scheduler polls while these land
		end
		write_word(addr, ctrl_word(task_pkg::fence_none, 1'b1, b_base, 4'd0, 4'd0, 8'd0));
		release_bus();
		for (int k = 0; k < first_b; k++) begin
			apply_task(k);
		end
		wait_halted();
		check_r0();
		@(posedge clk);
		addr = b_base;
		for (int k = first_b; k < n_tasks; k++) begin
			store_task(k, addr, addr);
		end
		write_word(addr, ctrl_word(task_pkg::fence_none, 1'b1, 6'd0, 4'd0, 4'd0, 8'd0));
		release_bus();
		resume <= 1'b1;
		@(posedge clk);
		resume <= 1'b0;
		@(negedge clk);
		assert (!halted) else give_up("halted still high after resume");
		for (int k = first_b; k < n_tasks; k++) begin
			apply_task(k);
		end
		wait_halted();
		check_r0();
		assert (starts_seen == n_tasks) else mismatch("task start count", n_tasks, starts_seen);
		$display(">>> PASS");
		$finish;
	end

endmodule

// ==== sched_top.f ====
rtl/task_pkg.sv
rtl/core_pkg.sv
rtl/task_mem.sv
rtl/mem_arbiter.sv
rtl/task_scheduler.sv
rtl/mini_core.sv
rtl/sched_top.sv
bench/sched_checker.sv
bench/sched_tb.sv

// ==== run.sh ====
#!/usr/bin/env bash
# Builds the scheduler testbench with Verilator and runs it

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module sched_tb -f sched_top.f -o sched_sim
status=$?
if [ "$status" -ne 0 ]; then
	echo "Verilator build failed with status $status"
	exit "$status"
fi

./obj_dir/sched_sim
status=$?
if [ "$status" -ne 0 ]; then
	echo "Simulation failed with status $status"
	exit "$status"
fi

exit 0
